// File: rtl/iab_pkg.sv
// input activation buffer package
// beat count, beat index type and the state encodings shared by the iab blocks

package iab_pkg;

  // ------------------------------------------------------------
  // beat geometry
  // ------------------------------------------------------------

  // chunks per activation word
  localparam int BEATS = 8;

  // index of the current beat on the imc bus
  typedef logic [$clog2(BEATS)-1:0] beat_idx_t;

  // ------------------------------------------------------------
  // state encodings
  // ------------------------------------------------------------

  // controller states, one word at a time
  typedef enum logic [2:0] {
    IDLE,
    COLLECT,
    ACCEPT,
    REQUEST_BUS,
    TRANSMIT
  } ctrl_state_t;

  // bus arbiter states
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

endpackage

// File: rtl/iab_bus_if.sv
// iab bus interface
// request/grant and beat transfer between one input wrapper and the bus arbiter

`timescale 1ns/1ns

interface iab_bus_if #(
  parameter int CHUNK_W = 16
);

  // request and transfer, driven by the wrapper
  logic               req;
  logic               drive;
  logic [CHUNK_W-1:0] data;
  iab_pkg::beat_idx_t beat;

  // grant and per-beat accept, driven by the arbiter
  logic               gnt;
  logic               accepted;

  modport wrapper (
    output req,
    output drive,
    output data,
    output beat,
    input  gnt,
    input  accepted
  );

  modport arbiter (
    input  req,
    input  drive,
    input  data,
    input  beat,
    output gnt,
    output accepted
  );

endinterface

// File: rtl/iab_controller.sv
// input buffer controller
// steps one activation word through collect, accept, bus request and transmit

`timescale 1ns/1ns

module iab_controller (
  input  logic               clk_i,
  input  logic               rstn_i,
  input  logic               a_valid_i,
  input  logic               gnt_i,
  input  logic               accepted_i,
  output logic               a_accepted_o,
  output logic               latch_o,
  output logic               bus_req_o,
  output logic               drive_bus_o,
  output iab_pkg::beat_idx_t beat_o
);

  iab_pkg::ctrl_state_t state_q;
  iab_pkg::ctrl_state_t state_d;
  iab_pkg::beat_idx_t   beat_q;
  logic                 last_beat;

  // ------------------------------------------------------------
  // state register and beat counter
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      state_q <= iab_pkg::IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // counts accepted beats, wraps to zero on the last one
  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      beat_q <= '0;
    end
    else if (state_q == iab_pkg::TRANSMIT && accepted_i)
    begin
      beat_q <= beat_q + 1'b1;
    end
    else if (state_q == iab_pkg::IDLE)
    begin
      beat_q <= '0;
    end
  end

  assign last_beat = (beat_q == iab_pkg::beat_idx_t'(iab_pkg::BEATS - 1));

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      iab_pkg::IDLE:
      begin
        if (a_valid_i)
        begin
          state_d = iab_pkg::COLLECT;
        end
      end
      // word is latched on this edge
      iab_pkg::COLLECT:
      begin
        if (a_valid_i)
        begin
          state_d = iab_pkg::ACCEPT;
        end
      end
      iab_pkg::ACCEPT:
      begin
        state_d = iab_pkg::REQUEST_BUS;
      end
      iab_pkg::REQUEST_BUS:
      begin
        if (gnt_i)
        begin
          state_d = iab_pkg::TRANSMIT;
        end
      end
      iab_pkg::TRANSMIT:
      begin
        if (last_beat && accepted_i)
        begin
          state_d = iab_pkg::IDLE;
        end
      end
      default:
      begin
        state_d = iab_pkg::IDLE;
      end
    endcase
  end

  // ------------------------------------------------------------
  // outputs decoded from state
  // ------------------------------------------------------------

  assign latch_o      = (state_q == iab_pkg::COLLECT);
  assign a_accepted_o = (state_q == iab_pkg::ACCEPT);
  assign bus_req_o    = (state_q == iab_pkg::REQUEST_BUS);
  assign drive_bus_o  = (state_q == iab_pkg::TRANSMIT);
  assign beat_o       = beat_q;

  // beats are only accepted while this port drives the bus
  a_accept_in_xfer : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    accepted_i |-> drive_bus_o
  );

  // beat index only moves on an accepted beat
  a_beat_hold : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    !accepted_i |=> $stable(beat_q)
  );

endmodule

// File: rtl/iab_buffer.sv
// activation word buffer
// holds one wide word and selects the chunk for the current beat

`timescale 1ns/1ns

module iab_buffer #(
  parameter int CHUNK_W = 16
) (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,
  input  logic                                 load_i,
  input  logic [iab_pkg::BEATS*CHUNK_W-1:0]    word_i,
  input  iab_pkg::beat_idx_t                   beat_i,
  output logic [CHUNK_W-1:0]                   chunk_o
);

  logic [iab_pkg::BEATS*CHUNK_W-1:0] word_q;

  // ------------------------------------------------------------
  // word register
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      word_q <= '0;
    end
    else if (load_i)
    begin
      word_q <= word_i;
    end
  end

  // ------------------------------------------------------------
  // chunk select
  // ------------------------------------------------------------

  // beat 0 is the least significant chunk
  assign chunk_o = word_q[beat_i*CHUNK_W +: CHUNK_W];

endmodule

// File: rtl/iab_wrapper.sv
// input activation wrapper
// one producer port, its controller and word buffer, and a bus interface to the arbiter

`timescale 1ns/1ns

module iab_wrapper #(
  parameter int CHUNK_W = 16
) (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              a_valid_i,
  input  logic [iab_pkg::BEATS*CHUNK_W-1:0] a_word_i,
  output logic                              a_accepted_o,
  iab_bus_if.wrapper                        bus
);

  logic               latch;
  logic               load;
  iab_pkg::beat_idx_t beat;

  iab_controller ctrl_i (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .a_valid_i    (a_valid_i),
    .gnt_i        (bus.gnt),
    .accepted_i   (bus.accepted),
    .a_accepted_o (a_accepted_o),
    .latch_o      (latch),
    .bus_req_o    (bus.req),
    .drive_bus_o  (bus.drive),
    .beat_o       (beat)
  );

  // capture only while the producer still holds valid
  assign load = latch && a_valid_i;

  iab_buffer #(
    .CHUNK_W (CHUNK_W)
  ) buf_i (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .load_i  (load),
    .word_i  (a_word_i),
    .beat_i  (beat),
    .chunk_o (bus.data)
  );

  assign bus.beat = beat;

endmodule

// File: rtl/iab_bus_arbiter.sv
// imc input bus arbiter
// round-robin grant held for a whole transfer, with the granted port muxed to the imc

`timescale 1ns/1ns

module iab_bus_arbiter #(
  parameter int CHUNK_W   = 16,
  parameter int NUM_PORTS = 2,
  localparam int IDX_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic               clk_i,
  input  logic               rstn_i,
  iab_bus_if.arbiter         ports [NUM_PORTS],
  output logic               imc_valid_o,
  output logic [CHUNK_W-1:0] imc_data_o,
  output iab_pkg::beat_idx_t imc_beat_o,
  output logic [IDX_W-1:0]   imc_port_o,
  input  logic               imc_accept_i
);

  iab_pkg::arb_state_t             state_q;
  logic [IDX_W-1:0]                gnt_idx_q;
  logic [IDX_W-1:0]                rr_ptr_q;
  logic [IDX_W-1:0]                pick_idx;
  logic                            pick_vld;
  logic [NUM_PORTS-1:0]            req_vec;
  logic [NUM_PORTS-1:0]            drive_vec;
  logic [NUM_PORTS-1:0]            gnt_vec;
  logic [NUM_PORTS-1:0][CHUNK_W-1:0] data_vec;
  iab_pkg::beat_idx_t              beat_vec [NUM_PORTS];

  // ------------------------------------------------------------
  // per-port unpacking and grant fan-out
  // ------------------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_port
    assign req_vec[i]        = ports[i].req;
    assign drive_vec[i]      = ports[i].drive;
    assign data_vec[i]       = ports[i].data;
    assign beat_vec[i]       = ports[i].beat;
    assign gnt_vec[i]        = (state_q == iab_pkg::ARB_BUSY) && (gnt_idx_q == IDX_W'(i));
    assign ports[i].gnt      = gnt_vec[i];
    // accept reaches the granted port only
    assign ports[i].accepted = gnt_vec[i] && drive_vec[i] && imc_accept_i;
  end

  // first requester at or after the pointer
  always_comb
  begin
    int cand;
    pick_vld = 1'b0;
    pick_idx = rr_ptr_q;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      cand = (int'(rr_ptr_q) + k) % NUM_PORTS;
      if (!pick_vld && req_vec[cand])
      begin
        pick_vld = 1'b1;
        pick_idx = IDX_W'(cand);
      end
    end
  end

  // ------------------------------------------------------------
  // grant state and round-robin pointer
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      state_q   <= iab_pkg::ARB_IDLE;
      gnt_idx_q <= '0;
      rr_ptr_q  <= '0;
    end
    else
    begin
      case (state_q)
        iab_pkg::ARB_IDLE:
        begin
          if (pick_vld)
          begin
            state_q   <= iab_pkg::ARB_BUSY;
            gnt_idx_q <= pick_idx;
            rr_ptr_q  <= IDX_W'((int'(pick_idx) + 1) % NUM_PORTS);
          end
        end
        // hold until the port has dropped both request and drive
        iab_pkg::ARB_BUSY:
        begin
          if (!req_vec[gnt_idx_q] && !drive_vec[gnt_idx_q])
          begin
            state_q <= iab_pkg::ARB_IDLE;
          end
        end
        default:
        begin
          state_q <= iab_pkg::ARB_IDLE;
        end
      endcase
    end
  end

  // imc side mux
  assign imc_valid_o = (state_q == iab_pkg::ARB_BUSY) && drive_vec[gnt_idx_q];
  assign imc_data_o  = data_vec[gnt_idx_q];
  assign imc_beat_o  = beat_vec[gnt_idx_q];
  assign imc_port_o  = gnt_idx_q;

  // only the granted port may drive the bus
  a_drive_granted : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (drive_vec & ~gnt_vec) == '0
  );

  // the granted port moves from request to drive on the next edge
  a_gnt_taken : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (state_q == iab_pkg::ARB_BUSY) && req_vec[gnt_idx_q] |=> drive_vec[gnt_idx_q]
  );

endmodule

// File: rtl/iab_top.sv
// imc input side top level
// NUM_PORTS activation wrappers sharing one imc input bus through a round-robin arbiter

`timescale 1ns/1ns

module iab_top #(
  parameter int CHUNK_W   = 16,
  parameter int NUM_PORTS = 2,
  localparam int IDX_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                             clk_i,
  input  logic                                             rstn_i,

  // producer side
  input  logic [NUM_PORTS-1:0]                             a_valid_i,
  input  logic [NUM_PORTS-1:0][iab_pkg::BEATS*CHUNK_W-1:0] a_word_i,
  output logic [NUM_PORTS-1:0]                             a_accepted_o,

  // imc side
  output logic                                             imc_valid_o,
  output logic [CHUNK_W-1:0]                               imc_data_o,
  output iab_pkg::beat_idx_t                               imc_beat_o,
  output logic [IDX_W-1:0]                                 imc_port_o,
  input  logic                                             imc_accept_i
);

  // one bus link per wrapper
  iab_bus_if #(
    .CHUNK_W (CHUNK_W)
  ) bus_if [NUM_PORTS] ();

  // ------------------------------------------------------------
  // input wrappers
  // ------------------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_wrap
    iab_wrapper #(
      .CHUNK_W (CHUNK_W)
    ) wrap_i (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .a_valid_i    (a_valid_i[p]),
      .a_word_i     (a_word_i[p]),
      .a_accepted_o (a_accepted_o[p]),
      .bus          (bus_if[p])
    );
  end

  // ------------------------------------------------------------
  // shared bus arbiter
  // ------------------------------------------------------------

  iab_bus_arbiter #(
    .CHUNK_W   (CHUNK_W),
    .NUM_PORTS (NUM_PORTS)
  ) arb_i (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .ports        (bus_if),
    .imc_valid_o  (imc_valid_o),
    .imc_data_o   (imc_data_o),
    .imc_beat_o   (imc_beat_o),
    .imc_port_o   (imc_port_o),
    .imc_accept_i (imc_accept_i)
  );

endmodule

// File: verif/tb_iab_top.sv
// testbench for the imc input activation buffers
// table-driven producer rows, random imc accept and a beat scoreboard

`timescale 1ns/1ns

module tb_iab_top #(
  parameter int SEED = 24465
);

  localparam int CHUNK_W    = 16;
  localparam int NUM_PORTS  = 2;
  localparam int WORD_W     = iab_pkg::BEATS * CHUNK_W;
  localparam int TIMEOUT    = 2000;
  localparam int MODE_PLAIN = 0;
  localparam int MODE_HOLD  = 1;
  localparam int MODE_RESET = 2;

  logic                             clk_i;
  logic                             rstn_i;
  logic [NUM_PORTS-1:0]             a_valid_i;
  logic [NUM_PORTS-1:0][WORD_W-1:0] a_word_i;
  logic [NUM_PORTS-1:0]             a_accepted_o;
  logic                             imc_valid_o;
  logic [CHUNK_W-1:0]               imc_data_o;
  iab_pkg::beat_idx_t               imc_beat_o;
  logic [0:0]                       imc_port_o;
  logic                             imc_accept_i;

  // stimulus table, one entry per row
  string             row_name [$];
  logic [1:0]        row_mask [$];
  logic [WORD_W-1:0] row_w0 [$];
  logic [WORD_W-1:0] row_w1 [$];
  int                row_pct [$];
  int                row_mode [$];

  // scoreboard
  string              test_name;
  int                 accept_pct;
  int                 err_cnt;
  logic [WORD_W-1:0]  offer_word [NUM_PORTS];
  logic [WORD_W-1:0]  exp_q [NUM_PORTS][$];
  int                 acc_cnt [NUM_PORTS];
  int                 start_cnt [NUM_PORTS];
  int                 done_cnt [NUM_PORTS];
  logic [NUM_PORTS-1:0] prev_acc;
  int                 rr_ptr;
  logic               in_xfer;
  int                 cur_port;
  logic [WORD_W-1:0]  cur_word;
  int                 beat_k;
  logic               hold_chk;
  logic               gap_chk;
  logic [CHUNK_W-1:0] held_data;
  iab_pkg::beat_idx_t held_beat;

  iab_top dut_i (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .a_valid_i    (a_valid_i),
    .a_word_i     (a_word_i),
    .a_accepted_o (a_accepted_o),
    .imc_valid_o  (imc_valid_o),
    .imc_data_o   (imc_data_o),
    .imc_beat_o   (imc_beat_o),
    .imc_port_o   (imc_port_o),
    .imc_accept_i (imc_accept_i)
  );

  always #5 clk_i = ~clk_i;

  // imc side accepts at the row's rate
  always @(posedge clk_i)
  begin
    imc_accept_i <= (int'($urandom_range(99)) < accept_pct);
  end

  // ------------------------------------------------------------
  // error handling
  // ------------------------------------------------------------

  task automatic stop_on_error();
    err_cnt++;
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error in test %s", test_name);
  endtask

  task automatic timeout_fail(string what);
    $display("timeout in test %s: %s", test_name, what);
    stop_on_error();
  endtask

  // ------------------------------------------------------------
  // scoreboard and monitors, sampled mid-cycle
  // ------------------------------------------------------------

  function automatic void clear_scoreboard();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      exp_q[p].delete();
      acc_cnt[p]   = 0;
      start_cnt[p] = 0;
      done_cnt[p]  = 0;
    end
    prev_acc = '0;
    rr_ptr   = 0;
    in_xfer  = 1'b0;
    hold_chk = 1'b0;
    gap_chk  = 1'b0;
  endfunction

  function automatic logic all_done();
    all_done = !in_xfer;
    for (int p = 0; p < NUM_PORTS; p++)
      if (done_cnt[p] != acc_cnt[p])
        all_done = 1'b0;
  endfunction

  task automatic check_producer_side();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (a_accepted_o[p])
      begin
        assert (!prev_acc[p])
        else
        begin
          $display("port %0d held a_accepted_o for more than one cycle", p);
          stop_on_error();
        end
        // a new word only after the previous transfer has ended
        assert (done_cnt[p] == acc_cnt[p])
        else
        begin
          $display("** Error [%s] port %0d transfers done at accept: expected %0d, actual %0d",
                   test_name, p, acc_cnt[p], done_cnt[p]);
          stop_on_error();
        end
        exp_q[p].push_back(offer_word[p]);
        acc_cnt[p]++;
      end
      prev_acc[p] = a_accepted_o[p];
    end
  endtask

  task automatic check_imc_side();
    int pick;
    int c;
    logic [CHUNK_W-1:0] exp_chunk;
    if (gap_chk)
    begin
      assert (!imc_valid_o)
      else
      begin
        $display("imc_valid_o stayed high right after the eighth beat");
        stop_on_error();
      end
      gap_chk = 1'b0;
    end
    // a stalled beat must hold
    if (hold_chk)
    begin
      assert (imc_valid_o && imc_data_o == held_data && imc_beat_o == held_beat)
      else
      begin
        $display("** Error [%s] stalled beat: expected beat %0d data %h, actual beat %0d data %h",
                 test_name, held_beat, held_data, imc_beat_o, imc_data_o);
        stop_on_error();
      end
      hold_chk = 1'b0;
    end
    if (imc_valid_o)
    begin
      if (!in_xfer)
      begin
        // next port at or after the pointer with a word waiting
        pick = -1;
        for (int k = 0; k < NUM_PORTS; k++)
        begin
          c = (rr_ptr + k) % NUM_PORTS;
          if (pick < 0 && acc_cnt[c] > start_cnt[c])
            pick = c;
        end
        assert (pick >= 0)
        else
        begin
          $display("imc_valid_o rose while no accepted word was waiting");
          stop_on_error();
        end
        assert (int'(imc_port_o) == pick)
        else
        begin
          $display("** Error [%s] served port: expected %0d, actual %0d",
                   test_name, pick, imc_port_o);
          stop_on_error();
        end
        cur_port = pick;
        cur_word = exp_q[pick].pop_front();
        start_cnt[pick]++;
        rr_ptr  = (pick + 1) % NUM_PORTS;
        beat_k  = 0;
        in_xfer = 1'b1;
      end
      assert (int'(imc_port_o) == cur_port)
      else
      begin
        $display("** Error [%s] port during transfer: expected %0d, actual %0d",
                 test_name, cur_port, imc_port_o);
        stop_on_error();
      end
      assert (int'(imc_beat_o) == beat_k)
      else
      begin
        $display("** Error [%s] imc_beat_o: expected %0d, actual %0d",
                 test_name, beat_k, imc_beat_o);
        stop_on_error();
      end
      // beat k carries chunk k, chunk 0 at the bottom of the word
      exp_chunk = CHUNK_W'(cur_word >> (beat_k * CHUNK_W));
      assert (imc_data_o == exp_chunk)
      else
      begin
        $display("** Error [%s] imc_data_o beat %0d: expected %h, actual %h",
                 test_name, beat_k, exp_chunk, imc_data_o);
        stop_on_error();
      end
      if (imc_accept_i)
      begin
        beat_k++;
        if (beat_k == iab_pkg::BEATS)
        begin
          in_xfer = 1'b0;
          gap_chk = 1'b1;
          done_cnt[cur_port]++;
        end
      end
      else
      begin
        hold_chk  = 1'b1;
        held_data = imc_data_o;
        held_beat = imc_beat_o;
      end
    end
    else
    begin
      assert (!in_xfer)
      else
      begin
        $display("imc_valid_o dropped in the middle of a transfer");
        stop_on_error();
      end
    end
  endtask

  always @(negedge clk_i)
  begin
    if (!rstn_i)
    begin
      assert (!imc_valid_o && a_accepted_o == '0)
      else
      begin
        $display("** Error [%s] valid/accepted in reset: expected 0/00, actual %b/%b",
                 test_name, imc_valid_o, a_accepted_o);
        stop_on_error();
      end
      clear_scoreboard();
    end
    else
    begin
      check_producer_side();
      check_imc_side();
    end
  end

  // ------------------------------------------------------------
  // producer model and row sequencing
  // ------------------------------------------------------------

  task automatic apply_reset();
    @(posedge clk_i);
    rstn_i    <= 1'b0;
    a_valid_i <= '0;
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
    repeat (2) @(posedge clk_i);
  endtask

  // offer one word and hold it until the accept pulse
  task automatic send_word(int p, logic [WORD_W-1:0] word);
    int cycles;
    @(posedge clk_i);
    a_valid_i[p] <= 1'b1;
    a_word_i[p]  <= word;
    offer_word[p] = word;
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while (!a_accepted_o[p] && cycles < TIMEOUT);
    if (!a_accepted_o[p])
      timeout_fail($sformatf("port %0d never pulsed a_accepted_o", p));
    @(posedge clk_i);
    a_valid_i[p] <= 1'b0;
  endtask

  task automatic run_producer(int p, int r);
    logic [WORD_W-1:0] word;
    word = (p == 0) ? row_w0[r] : row_w1[r];
    send_word(p, word);
    if (row_mode[r] == MODE_HOLD)
      send_word(p, ~word);
  endtask

  task automatic wait_transfers_done();
    int cycles;
    cycles = 0;
    while (!all_done() && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!all_done())
      timeout_fail("not every accepted word was sent to the imc");
    repeat (3) @(posedge clk_i);
  endtask

  task automatic reset_mid_transfer();
    int cycles;
    cycles = 0;
    while (!(imc_valid_o && int'(imc_beat_o) == 3) && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!(imc_valid_o && int'(imc_beat_o) == 3))
      timeout_fail("the transfer never reached beat 3");
    apply_reset();
  endtask

  task automatic run_row(int r);
    test_name  = row_name[r];
    accept_pct = row_pct[r];
    fork
      if (row_mask[r][0]) run_producer(0, r);
      if (row_mask[r][1]) run_producer(1, r);
    join
    if (row_mode[r] == MODE_RESET)
      reset_mid_transfer();
    else
      wait_transfers_done();
  endtask

  function automatic void add_row(string name, logic [1:0] mask, logic [WORD_W-1:0] w0,
                                  logic [WORD_W-1:0] w1, int pct, int mode);
    row_name.push_back(name);
    row_mask.push_back(mask);
    row_w0.push_back(w0);
    row_w1.push_back(w1);
    row_pct.push_back(pct);
    row_mode.push_back(mode);
  endfunction

  // name, port mask, word for port 0, word for port 1, accept percent, mode
  function automatic void build_table();
    add_row("both_after_reset", 2'b11, 128'h0123_4567_89ab_cdef_0f1e_2d3c_4b5a_6978,
            128'hfedc_ba98_7654_3210_8796_a5b4_c3d2_e1f0, 100, MODE_PLAIN);
    add_row("single_p0", 2'b01, 128'h1111_2222_3333_4444_5555_6666_7777_8888,
            128'h0, 100, MODE_PLAIN);
    add_row("single_p1", 2'b10, 128'h0, 128'h9999_aaaa_bbbb_cccc_dddd_eeee_ffff_0001,
            100, MODE_PLAIN);
    add_row("backpressure_30", 2'b10, 128'h0, 128'hdead_beef_cafe_f00d_1234_5678_9abc_def0,
            30, MODE_PLAIN);
    add_row("backpressure_70", 2'b01, 128'h0bad_c0de_5eed_face_a5a5_5a5a_c3c3_3c3c,
            128'h0, 70, MODE_PLAIN);
    add_row("fair_1", 2'b11, 128'h8001_4002_2004_1008_0810_0420_0240_0180,
            128'h7ffe_bffd_dffb_eff7_f7ef_fbdf_fdbf_fe7f, 50, MODE_PLAIN);
    add_row("fair_2", 2'b11, 128'h3141_5926_5358_9793_2384_6264_3383_2795,
            128'h2718_2818_2845_9045_2353_6028_7471_3526, 100, MODE_PLAIN);
    add_row("single_p1_b", 2'b10, 128'h0, 128'h0f0f_f0f0_00ff_ff00_0001_8000_7fff_fffe,
            100, MODE_PLAIN);
    add_row("fair_3", 2'b11, 128'h1357_9bdf_2468_ace0_1122_3344_5566_7788,
            128'h99aa_bbcc_ddee_ff00_8765_4321_0fed_cba9, 70, MODE_PLAIN);
    add_row("producer_hold", 2'b01, 128'h6a09_e667_bb67_ae85_3c6e_f372_a54f_f53a,
            128'h0, 60, MODE_HOLD);
    add_row("producer_hold_both", 2'b11, 128'h510e_527f_9b05_688c_1f83_d9ab_5be0_cd19,
            128'hcbbb_9d5d_629a_292a_9159_015a_152f_ecd8, 80, MODE_HOLD);
    add_row("reset_mid", 2'b01, 128'h4242_4242_abab_abab_1357_2468_0000_ffff,
            128'h0, 100, MODE_RESET);
    add_row("after_reset", 2'b01, 128'hc001_d00d_b00b_f00d_0123_3210_4567_7654,
            128'h0, 100, MODE_PLAIN);
    add_row("fair_after_reset", 2'b11, 128'h5555_aaaa_3333_cccc_0f0f_f0f0_00ff_ff00,
            128'haaaa_5555_cccc_3333_f0f0_0f0f_ff00_00ff, 30, MODE_PLAIN);
  endfunction

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial
  begin
    clk_i        = 1'b0;
    rstn_i       = 1'b0;
    a_valid_i    = '0;
    a_word_i     = '0;
    imc_accept_i = 1'b0;
    accept_pct   = 100;
    err_cnt      = 0;
    test_name    = "reset";
    clear_scoreboard();
    void'($urandom(SEED));
    build_table();
    apply_reset();
    for (int r = 0; r < row_name.size(); r++)
      run_row(r);
    test_name = "end";
    assert (all_done() && exp_q[0].size() == 0 && exp_q[1].size() == 0)
    else
    begin
      $display("accepted words were left unsent at the end of the run");
      stop_on_error();
    end
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: imc_iab.f
rtl/iab_pkg.sv
rtl/iab_bus_if.sv
rtl/iab_controller.sv
rtl/iab_buffer.sv
rtl/iab_wrapper.sv
rtl/iab_bus_arbiter.sv
rtl/iab_top.sv
verif/tb_iab_top.sv

// File: Makefile
# Verilator build, run, lint and clean for the imc input activation buffers

VERILATOR  ?= verilator
TOP        ?= tb_iab_top
LINT_TOP   ?= iab_top
SEED       ?= 24465
FILELIST   ?= imc_iab.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
